/* processorTop.f */
+incdir+include
src/cpuPkg.sv
src/alu.sv
src/divider.sv
src/controlUnit.sv
src/dataPath.sv
src/processorTop.sv
test/processorChecker.sv
test/processorTb.sv

/* Bender.yml */
package:
  name: processor_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/cpuPkg.sv
      - src/alu.sv
      - src/divider.sv
      - src/controlUnit.sv
      - src/dataPath.sv
      - src/processorTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/processorChecker.sv
      - test/processorTb.sv

/* test/processorTb.sv */
`include "cpu_defs.svh"

module processorTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int InstrCount = 40;
    localparam int CycleLimit = InstrCount * 30 + 100;   // Divide, the slowest op, needs 22

    logic                                   clock;
    logic                                   reset;
    logic [`DATA_WIDTH-1:0]                 readData;
    logic                                   done;
    cpuPkg::memRequest                      memReq;
    cpuPkg::memRequest                      heldReq;     // Request seen mid-cycle
    logic [`MEM_DEPTH-1:0][`DATA_WIDTH-1:0] image;       // Untouched program image
    logic [`DATA_WIDTH-1:0]                 memory [`MEM_DEPTH];
    logic                                   imageReady;
    logic                                   runFinished;
    logic                                   reported;
    int                                     errorTotal;
    integer                                 seed;
    int                                     cycleCount;
    bit                                     timedOut;

    processorTop DUT (
        .clock    (clock),
        .reset    (reset),
        .readData (readData),
        .memReq   (memReq),
        .done     (done)
    );

    processorChecker uChecker (
        .clock       (clock),
        .reset       (reset),
        .memReq      (memReq),
        .done        (done),
        .imageReady  (imageReady),
        .image       (image),
        .runFinished (runFinished),
        .errorTotal  (errorTotal),
        .reported    (reported)
    );

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
    end

    always @(negedge clock) begin
        heldReq <= memReq;                       // Outputs settled by now
    end

    // Registered read, write at the edge that ends the write cycle
    always @(posedge clock) begin
        #2;
        if (heldReq.write)
            memory[heldReq.address] = heldReq.writeData;
        else
            readData = memory[heldReq.address];
    end

    task automatic buildProgram();
        logic [`DATA_WIDTH-1:0] opcodes [InstrCount];
        logic [`DATA_WIDTH-1:0] firstOperand [InstrCount];
        logic [`DATA_WIDTH-1:0] secondOperand [InstrCount];
        int                     lengths [InstrCount];
        int                     pick;
        int                     skip;
        int                     address;
        for (int i = 0; i < `MEM_DEPTH; i++)
            image[i] = `DATA_WIDTH'(i) ^ 8'h5A;  // Background, never executed
        for (int i = 0; i < InstrCount; i++) begin
            pick = $unsigned($random(seed)) % 20;
            if (pick >= 17)
                opcodes[i] = `OP_JUMP;           // Extra weight on jumps
            else if (pick < 4)
                opcodes[i] = `DATA_WIDTH'(pick + 1);          // 01h to 04h
            else
                opcodes[i] = `DATA_WIDTH'((pick - 3) << 4);   // 10h to D0h, C0h and D0h unknown
            firstOperand[i]  = $random(seed);
            secondOperand[i] = $random(seed);
            if ((opcodes[i] == `OP_DIV || opcodes[i] == `OP_REM) && ($random(seed) & 7) == 0)
                secondOperand[i] = '0;           // Zero divisor now and then
            if (opcodes[i] inside {`OP_INC, `OP_DEC, `OP_NOT, `OP_JUMP})
                lengths[i] = 2;
            else
                lengths[i] = 3;
        end
        for (int i = 0; i < InstrCount; i++) begin
            if (opcodes[i] == `OP_JUMP) begin
                skip = 1 + $unsigned($random(seed)) % 2;
                if (i + skip >= InstrCount)
                    skip = InstrCount - 1 - i;   // Never past the halt
                firstOperand[i] = '0;
                for (int j = 1; j <= skip; j++)
                    firstOperand[i] = firstOperand[i] + `DATA_WIDTH'(lengths[i + j]);
            end
        end
        address = 0;
        for (int i = 0; i < InstrCount; i++) begin
            image[address]     = opcodes[i];
            image[address + 1] = firstOperand[i];
            if (lengths[i] == 3)
                image[address + 2] = secondOperand[i];
            address += lengths[i];
        end
        image[address] = `OP_HALT;
    endtask

    initial begin
        clock       = 1'b0;
        reset       = 1'b0;
        readData    = '0;
        heldReq     = '0;
        imageReady  = 1'b0;
        runFinished = 1'b0;
        seed        = 32'h5171;
        cycleCount  = 0;
        timedOut    = 1'b0;
        buildProgram();
        for (int i = 0; i < `MEM_DEPTH; i++)
            memory[i] = image[i];
        imageReady = 1'b1;
        repeat (5) @(posedge clock);
        #2 reset = 1'b1;
        while (!done && cycleCount < CycleLimit)
            @(negedge clock);
        if (!done) begin
            timedOut = 1'b1;
            $display("Timeout: done did not rise within %0d cycles", CycleLimit);
        end else begin
            repeat (5) @(negedge clock);         // Window for stray writes after halt
        end
        runFinished = 1'b1;
        wait (reported);
        if (timedOut || errorTotal != 0) begin
            $display("Errors found");
        end else begin
            $display("No errors");
        end
        $finish;
    end

endmodule

/* test/processorChecker.sv */
`include "cpu_defs.svh"

module processorChecker (
    input  logic                                   clock,
    input  logic                                   reset,
    input  cpuPkg::memRequest                      memReq,
    input  logic                                   done,
    input  logic                                   imageReady,
    input  logic [`MEM_DEPTH-1:0][`DATA_WIDTH-1:0] image,
    input  logic                                   runFinished,
    output int                                     errorTotal,
    output logic                                   reported
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [`DATA_WIDTH-1:0] expOpcode [$];
    logic [`DATA_WIDTH-1:0] expResult [$];
    int                     checkCount [1:6];
    int                     errorCount [1:6];
    int                     writeCount;
    int                     zeroDivisors;
    bit                     doneSeen;

    function automatic int behaviorOf(logic [`DATA_WIDTH-1:0] opcode);
        case (opcode)
            `OP_INC, `OP_DEC, `OP_NOT: return 3;
            `OP_JUMP:                  return 4;
            `OP_DIV, `OP_REM:          return 5;
            `OP_AND, `OP_OR, `OP_XOR, `OP_NAND, `OP_NOR, `OP_XNOR: return 2;
            default:                   return 1;     // ADD, SUB, MUL, unknown
        endcase
    endfunction

    function automatic logic [`DATA_WIDTH-1:0] referenceResult(
        logic [`DATA_WIDTH-1:0] opcode,
        logic [`DATA_WIDTH-1:0] a,
        logic [`DATA_WIDTH-1:0] b
    );
        case (opcode)
            `OP_INC:  return a + 8'd1;
            `OP_DEC:  return a - 8'd1;
            `OP_NOT:  return ~a;
            `OP_JUMP: return b;                      // Distance is the record
            `OP_ADD:  return a + b;
            `OP_SUB:  return a - b;
            `OP_MUL:  return a * b;                  // Low byte
            `OP_DIV:  return (b == 0) ? 8'hFF : a / b;
            `OP_REM:  return (b == 0) ? 8'hFF : a % b;
            `OP_AND:  return a & b;
            `OP_OR:   return a | b;
            `OP_XOR:  return a ^ b;
            `OP_NAND: return ~(a & b);
            `OP_NOR:  return ~(a | b);
            `OP_XNOR: return ~(a ^ b);
            default:  return '0;
        endcase
    endfunction

    function automatic string behaviorName(int index);
        case (index)
            1:       return "arithmetic and unknown opcode records";
            2:       return "logic records";
            3:       return "increment, decrement and invert records";
            4:       return "jump results and opcode sequence";
            5:       return "divide and remainder records";
            default: return "done, answer addresses and record count";
        endcase
    endfunction

    // Walk the program image the way the processor should
    task automatic buildExpected();
        logic [`DATA_WIDTH-1:0] pc;
        logic [`DATA_WIDTH-1:0] opcode;
        logic [`DATA_WIDTH-1:0] a;
        logic [`DATA_WIDTH-1:0] b;
        bit                     halted;
        pc     = '0;
        halted = 1'b0;
        for (int step = 0; step < `MEM_DEPTH && !halted; step++) begin
            opcode = image[pc];
            a      = '0;
            b      = '0;
            if (opcode == `OP_HALT) begin
                halted = 1'b1;
            end else begin
                if (behaviorOf(opcode) == 3) begin
                    a  = image[pc + 1];
                    pc = pc + 2;
                end else if (opcode == `OP_JUMP) begin
                    b  = image[pc + 1];
                    pc = pc + 2 + b;                 // Relative to next instruction
                end else begin
                    a  = image[pc + 1];
                    b  = image[pc + 2];
                    pc = pc + 3;
                end
                if (behaviorOf(opcode) == 5 && b == 0)
                    zeroDivisors++;
                expOpcode.push_back(opcode);
                expResult.push_back(referenceResult(opcode, a, b));
            end
        end
    endtask

    task automatic compareWrite();
        int                     record;
        int                     behavior;
        logic [`DATA_WIDTH-1:0] expectedAddress;
        record          = writeCount / 2;
        expectedAddress = `DATA_WIDTH'(`ANSWER_BASE + writeCount);   // Consecutive answer slots
        checkCount[6]++;
        if (memReq.address !== expectedAddress) begin
            errorCount[6]++;
            $display("ERROR address at answer byte %0d: expected %h, actual %h",
                     writeCount, expectedAddress, memReq.address);
        end
        if (record >= expOpcode.size()) begin
            checkCount[6]++;
            errorCount[6]++;
            $display("Extra answer byte %0d written, the model has only %0d records",
                     writeCount, expOpcode.size());
        end else if (writeCount % 2 == 0) begin
            checkCount[4]++;                         // Opcode order shows jump skips
            if (memReq.writeData !== expOpcode[record]) begin
                errorCount[4]++;
                $display("ERROR writeData opcode of record %0d: expected %h, actual %h",
                         record, expOpcode[record], memReq.writeData);
            end
        end else begin
            behavior = behaviorOf(expOpcode[record]);
            checkCount[behavior]++;
            if (memReq.writeData !== expResult[record]) begin
                errorCount[behavior]++;
                $display("ERROR writeData result of record %0d (opcode %h): expected %h, actual %h",
                         record, expOpcode[record], expResult[record], memReq.writeData);
            end
        end
        writeCount++;
    endtask

    always @(negedge clock) begin
        if (reset && imageReady) begin
            if (memReq.write && done) begin
                checkCount[6]++;
                errorCount[6]++;
                $display("Memory write at address %h after done was raised", memReq.address);
            end else if (memReq.write) begin
                compareWrite();
            end
            if (doneSeen) begin
                checkCount[6]++;
                if (!done) begin
                    errorCount[6]++;
                    $display("done fell again after it had been raised");
                end
            end
            if (done && !doneSeen) begin
                doneSeen = 1'b1;
                checkCount[6]++;
                if (writeCount != 2 * expOpcode.size()) begin
                    errorCount[6]++;
                    $display("done rose after %0d answer bytes, the model expects %0d",
                             writeCount, 2 * expOpcode.size());
                end
            end
        end
    end

    task automatic reportResults();
        int    totalChecks;
        string detail;
        checkCount[6] += 2;
        if (!doneSeen) begin
            errorCount[6]++;
            $display("done never rose after the halt instruction");
        end
        if (writeCount != 2 * expOpcode.size()) begin
            errorCount[6]++;
            $display("Wrote %0d answer bytes in all, the model expects %0d",
                     writeCount, 2 * expOpcode.size());
        end
        totalChecks = 0;
        errorTotal  = 0;
        for (int i = 1; i <= 6; i++) begin
            detail = (i == 5) ? $sformatf(", %0d with zero divisor", zeroDivisors) : "";
            $display("Test %0d %s%s: %0d checks, %0d mismatches, %s", i, behaviorName(i),
                     detail, checkCount[i], errorCount[i], (errorCount[i] == 0) ? "pass" : "FAIL");
            totalChecks += checkCount[i];
            errorTotal  += errorCount[i];
        end
        $display("Checks passed %0d, failed %0d", totalChecks - errorTotal, errorTotal);
    endtask

    initial begin
        reported     = 1'b0;
        errorTotal   = 0;
        writeCount   = 0;
        zeroDivisors = 0;
        doneSeen     = 1'b0;
        for (int i = 1; i <= 6; i++) begin
            checkCount[i] = 0;
            errorCount[i] = 0;
        end
        wait (imageReady);
        buildExpected();
        wait (runFinished);
        reportResults();
        reported = 1'b1;
    end

endmodule

/* src/processorTop.sv */
`include "cpu_defs.svh"

module processorTop (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [`DATA_WIDTH-1:0] readData,
    output cpuPkg::memRequest      memReq,
    output logic                   done
);

    cpuPkg::controlWord     control;
    cpuPkg::divResult       division;
    logic [`DATA_WIDTH-1:0] ir;
    logic [`DATA_WIDTH-1:0] operandA;
    logic [`DATA_WIDTH-1:0] operandB;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic                   divStart;
    logic                   divDone;

    controlUnit uControl (
        .clock    (clock),
        .reset    (reset),
        .ir       (ir),
        .divDone  (divDone),
        .control  (control),
        .divStart (divStart),
        .done     (done)
    );

    dataPath uDataPath (
        .clock     (clock),
        .reset     (reset),
        .control   (control),
        .readData  (readData),
        .aluResult (aluResult),
        .ir        (ir),
        .operandA  (operandA),
        .operandB  (operandB),
        .memReq    (memReq)
    );

    alu uAlu (
        .opcode   (ir),
        .operandA (operandA),
        .operandB (operandB),
        .division (division),
        .result   (aluResult)
    );

    divider uDivider (
        .clock    (clock),
        .reset    (reset),
        .divStart (divStart),
        .dividend (operandA),
        .divisor  (operandB),
        .division (division),
        .divDone  (divDone)
    );

endmodule

/* src/dataPath.sv */
`include "cpu_defs.svh"

module dataPath (
    input  logic                   clock,
    input  logic                   reset,
    input  cpuPkg::controlWord     control,
    input  logic [`DATA_WIDTH-1:0] readData,   // Registered read, one cycle after MAR
    input  logic [`DATA_WIDTH-1:0] aluResult,
    output logic [`DATA_WIDTH-1:0] ir,
    output logic [`DATA_WIDTH-1:0] operandA,
    output logic [`DATA_WIDTH-1:0] operandB,
    output cpuPkg::memRequest      memReq
);

    logic [`DATA_WIDTH-1:0] pc;
    logic [`DATA_WIDTH-1:0] mar;
    logic [`DATA_WIDTH-1:0] pr;         // Answer pointer
    logic [`DATA_WIDTH-1:0] c;          // Result holding register
    logic [`DATA_WIDTH-1:0] bus1;
    logic [`DATA_WIDTH-1:0] bus2;

    always_comb begin
        case (control.bus1Sel)
            cpuPkg::srcPc: bus1 = pc;
            cpuPkg::srcA:  bus1 = operandA;
            cpuPkg::srcB:  bus1 = operandB;
            cpuPkg::srcC:  bus1 = c;
            cpuPkg::srcPr: bus1 = pr;
            cpuPkg::srcIr: bus1 = ir;
            default:       bus1 = '0;
        endcase
    end

    always_comb begin
        case (control.bus2Sel)
            cpuPkg::fromBus1:   bus2 = bus1;
            cpuPkg::constOne:   bus2 = `DATA_WIDTH'(1);
            cpuPkg::fromMemory: bus2 = readData;
            cpuPkg::fromAlu:    bus2 = aluResult;
            default:            bus2 = '0;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc  <= '0;
            pr  <= `ANSWER_BASE;
            mar <= '0;
            ir  <= '0;
        end else begin
            if (control.pcJump)
                pc <= pc + bus2;                   // Relative to byte after operand
            else if (control.pcInc)
                pc <= pc + 1'b1;
            if (control.prInc)
                pr <= pr + 1'b1;                   // Advances with each answer byte
            if (control.marLoad)
                mar <= bus2;
            if (control.irLoad)
                ir <= bus2;
        end
    end

    always_ff @(posedge clock) begin
        if (control.aLoad)
            operandA <= bus2;
        if (control.bLoad)
            operandB <= bus2;
        if (control.cLoad)
            c <= bus2;
    end

    always_comb begin
        memReq.address   = control.memWrite ? pr : mar;  // Answer slot while writing
        memReq.writeData = bus1;
        memReq.write     = control.memWrite;
    end

    // Answer area must not wrap back into program space
    assert property (@(posedge clock) disable iff (!reset) pr >= `ANSWER_BASE);

endmodule

/* src/controlUnit.sv */
`include "cpu_defs.svh"

module controlUnit (
    input  logic                   clock,
    input  logic                   reset,
    input  logic [`DATA_WIDTH-1:0] ir,
    input  logic                   divDone,
    output cpuPkg::controlWord     control,
    output logic                   divStart,
    output logic                   done
);

    cpuPkg::cpuState state;
    cpuPkg::cpuState nextState;
    logic            isSingle;      // INC, DEC, NOT
    logic            isDivide;      // DIV, REM

    assign isSingle = (ir == `OP_INC) || (ir == `OP_DEC) || (ir == `OP_NOT);
    assign isDivide = (ir == `OP_DIV) || (ir == `OP_REM);

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= cpuPkg::sFetch0;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            cpuPkg::sFetch0:    nextState = cpuPkg::sFetch1;
            cpuPkg::sFetch1:    nextState = cpuPkg::sFetch2;
            cpuPkg::sFetch2:    nextState = cpuPkg::sDecode;
            cpuPkg::sDecode: begin
                if (ir == `OP_HALT)
                    nextState = cpuPkg::sHalt;
                else if (ir == `OP_JUMP)
                    nextState = cpuPkg::sOperandB0;    // Distance only
                else if (isSingle)
                    nextState = cpuPkg::sLoadOne;
                else
                    nextState = cpuPkg::sOperandA0;
            end
            cpuPkg::sLoadOne:   nextState = cpuPkg::sOperandA0;
            cpuPkg::sOperandA0: nextState = cpuPkg::sOperandA1;
            cpuPkg::sOperandA1: nextState = cpuPkg::sOperandA2;
            cpuPkg::sOperandA2: nextState = isSingle ? cpuPkg::sExecute : cpuPkg::sOperandB0;
            cpuPkg::sOperandB0: nextState = cpuPkg::sOperandB1;
            cpuPkg::sOperandB1: nextState = cpuPkg::sOperandB2;
            cpuPkg::sOperandB2: nextState = (ir == `OP_JUMP) ? cpuPkg::sJump : cpuPkg::sExecute;
            cpuPkg::sExecute:   nextState = isDivide ? cpuPkg::sDivWait : cpuPkg::sStoreOpcode;
            cpuPkg::sDivWait: begin
                if (divDone)
                    nextState = cpuPkg::sStoreOpcode;
            end
            cpuPkg::sJump:        nextState = cpuPkg::sStoreOpcode;
            cpuPkg::sStoreOpcode: nextState = cpuPkg::sStoreResult;
            cpuPkg::sStoreResult: nextState = cpuPkg::sFetch0;
            cpuPkg::sHalt:        nextState = cpuPkg::sHalt;    // Sticky until reset
            default:              nextState = cpuPkg::sFetch0;
        endcase
    end

    always_comb begin
        control         = '0;
        control.bus1Sel = cpuPkg::srcPc;
        control.bus2Sel = cpuPkg::fromBus1;
        case (state)
            cpuPkg::sFetch0, cpuPkg::sOperandA0, cpuPkg::sOperandB0: begin
                control.marLoad = 1'b1;                     // MAR <= PC
            end
            cpuPkg::sFetch1, cpuPkg::sOperandA1, cpuPkg::sOperandB1: begin
                control.pcInc = 1'b1;                       // Read in flight
            end
            cpuPkg::sFetch2: begin
                control.bus2Sel = cpuPkg::fromMemory;
                control.irLoad  = 1'b1;
            end
            cpuPkg::sLoadOne: begin
                control.bus2Sel = cpuPkg::constOne;
                control.bLoad   = 1'b1;
            end
            cpuPkg::sOperandA2: begin
                control.bus2Sel = cpuPkg::fromMemory;
                control.aLoad   = 1'b1;
            end
            cpuPkg::sOperandB2: begin
                control.bus2Sel = cpuPkg::fromMemory;
                control.bLoad   = 1'b1;
            end
            cpuPkg::sExecute: begin
                control.bus2Sel = cpuPkg::fromAlu;
                control.cLoad   = !isDivide;                // Divide loads C later
            end
            cpuPkg::sDivWait: begin
                control.bus2Sel = cpuPkg::fromAlu;
                control.cLoad   = divDone;
            end
            cpuPkg::sJump: begin
                control.bus1Sel = cpuPkg::srcB;             // PC += B
                control.pcJump  = 1'b1;
            end
            cpuPkg::sStoreOpcode: begin
                control.bus1Sel  = cpuPkg::srcIr;
                control.memWrite = 1'b1;
                control.prInc    = 1'b1;
            end
            cpuPkg::sStoreResult: begin
                control.bus1Sel  = (ir == `OP_JUMP) ? cpuPkg::srcB : cpuPkg::srcC;
                control.memWrite = 1'b1;
                control.prInc    = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign divStart = (state == cpuPkg::sExecute) && isDivide;
    assign done     = (state == cpuPkg::sHalt);

    // Divider answers only while the FSM waits for it
    assert property (@(posedge clock) disable iff (!reset)
        divDone |-> (state == cpuPkg::sDivWait));

endmodule

/* src/divider.sv */
`include "cpu_defs.svh"

module divider (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   divStart,   // One-cycle strobe
    input  logic [`DATA_WIDTH-1:0] dividend,
    input  logic [`DATA_WIDTH-1:0] divisor,
    output cpuPkg::divResult       division,
    output logic                   divDone     // One-cycle strobe
);

    localparam int CountWidth = $clog2(`DIV_STEPS + 1);

    logic                   busy;
    logic [CountWidth-1:0]  stepsLeft;
    logic [`DATA_WIDTH-1:0] quotient;       // Shifts dividend out, quotient bits in
    logic [`DATA_WIDTH-1:0] remainder;
    logic [`DATA_WIDTH-1:0] divisorReg;
    logic [`DATA_WIDTH:0]   shifted;        // Partial remainder with next dividend bit
    logic [`DATA_WIDTH:0]   trial;          // MSB set means restore

    assign shifted = {remainder, quotient[`DATA_WIDTH-1]};
    assign trial   = shifted - {1'b0, divisorReg};

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            busy      <= 1'b0;
            stepsLeft <= '0;
            divDone   <= 1'b0;
        end else begin
            divDone <= 1'b0;
            if (divStart) begin
                busy      <= (divisor != '0);      // Zero divisor skips the loop
                stepsLeft <= CountWidth'(`DIV_STEPS);
                divDone   <= (divisor == '0);
            end else if (busy) begin
                stepsLeft <= stepsLeft - 1'b1;
                if (stepsLeft == CountWidth'(1)) begin
                    busy    <= 1'b0;
                    divDone <= 1'b1;               // Last step lands this edge
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (divStart) begin
            divisorReg <= divisor;
            if (divisor == '0) begin
                quotient  <= '1;                   // FFh error value
                remainder <= '1;
            end else begin
                quotient  <= dividend;
                remainder <= '0;
            end
        end else if (busy) begin
            if (trial[`DATA_WIDTH]) begin
                remainder <= shifted[`DATA_WIDTH-1:0];          // Restore
                quotient  <= {quotient[`DATA_WIDTH-2:0], 1'b0};
            end else begin
                remainder <= trial[`DATA_WIDTH-1:0];
                quotient  <= {quotient[`DATA_WIDTH-2:0], 1'b1};
            end
        end
    end

    assign division.quotient  = quotient;
    assign division.remainder = remainder;

    // Controller waits on a single strobe per division
    assert property (@(posedge clock) disable iff (!reset) divDone |=> !divDone);

endmodule

/* src/alu.sv */
`include "cpu_defs.svh"

module alu (
    input  logic [`DATA_WIDTH-1:0] opcode,      // Straight from IR
    input  logic [`DATA_WIDTH-1:0] operandA,
    input  logic [`DATA_WIDTH-1:0] operandB,
    input  cpuPkg::divResult       division,    // Held by divider after divDone
    output logic [`DATA_WIDTH-1:0] result
);

    logic [`DATA_WIDTH-1:0] sum;
    logic [`DATA_WIDTH-1:0] difference;
    logic [`DATA_WIDTH-1:0] product;

    assign sum        = operandA + operandB;   // Also serves INC with B = 1
    assign difference = operandA - operandB;   // Also serves DEC with B = 1
    assign product    = operandA * operandB;   // Truncated to low byte

    always_comb begin
        case (opcode)
            `OP_INC:  result = sum;
            `OP_DEC:  result = difference;
            `OP_NOT:  result = ~operandA;
            `OP_ADD:  result = sum;
            `OP_SUB:  result = difference;
            `OP_MUL:  result = product;
            `OP_DIV:  result = division.quotient;
            `OP_REM:  result = division.remainder;
            `OP_AND:  result = operandA & operandB;
            `OP_OR:   result = operandA | operandB;
            `OP_XOR:  result = operandA ^ operandB;
            `OP_NAND: result = ~(operandA & operandB);
            `OP_NOR:  result = ~(operandA | operandB);
            `OP_XNOR: result = ~(operandA ^ operandB);
            default:  result = '0;                 // Unknown ops, halt and jump
        endcase
    end

endmodule

/* src/cpuPkg.sv */
`include "cpu_defs.svh"

package cpuPkg;

    typedef enum logic [4:0] {
        sFetch0,        // MAR <= PC
        sFetch1,        // PC++, memory registers the read
        sFetch2,        // IR <= readData
        sDecode,
        sLoadOne,       // B <= 1 for single-operand ops
        sOperandA0,
        sOperandA1,
        sOperandA2,
        sOperandB0,
        sOperandB1,
        sOperandB2,
        sExecute,
        sDivWait,       // Hold until divider finishes
        sJump,
        sStoreOpcode,
        sStoreResult,
        sHalt
    } cpuState;

    typedef enum logic [2:0] {
        srcPc,
        srcA,
        srcB,
        srcC,
        srcPr,
        srcIr
    } bus1Source;

    typedef enum logic [1:0] {
        fromBus1,
        constOne,
        fromMemory,
        fromAlu
    } bus2Source;

    typedef struct packed {
        logic      irLoad;
        logic      marLoad;
        logic      aLoad;
        logic      bLoad;
        logic      cLoad;
        logic      pcInc;
        logic      pcJump;      // PC <= PC + bus2
        logic      prInc;
        logic      memWrite;
        bus1Source bus1Sel;
        bus2Source bus2Sel;
    } controlWord;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] address;
        logic [`DATA_WIDTH-1:0] writeData;
        logic                   write;
    } memRequest;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] quotient;
        logic [`DATA_WIDTH-1:0] remainder;
    } divResult;

endpackage

/* include/cpu_defs.svh */
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define DATA_WIDTH  8       // Byte width of every register and bus
`define MEM_DEPTH   256     // External memory size in bytes
`define ANSWER_BASE 8'h80   // First byte of the answer area, PR reset value
`define DIV_STEPS   `DATA_WIDTH // One shift-subtract per quotient bit

`define OP_HALT 8'h00   // Stop and raise done
`define OP_INC  8'h01   // A + 1
`define OP_DEC  8'h02   // A - 1
`define OP_NOT  8'h03   // ~A
`define OP_JUMP 8'h04   // PC += B
`define OP_ADD  8'h10
`define OP_SUB  8'h20
`define OP_MUL  8'h30   // Low byte only
`define OP_DIV  8'h40   // Quotient, FFh on zero divisor
`define OP_REM  8'h50   // Remainder, FFh on zero divisor
`define OP_AND  8'h60
`define OP_OR   8'h70
`define OP_XOR  8'h80
`define OP_NAND 8'h90
`define OP_NOR  8'hA0
`define OP_XNOR 8'hB0

`endif
